// File: design/cnn_pkg.sv
package cnn_pkg;

  // pixel and weight width
  localparam int DATA_LEN = 8;
  // tile geometry, same padding so the border is one pixel
  localparam int TILE_DIM = 4;
  localparam int PAD_DIM = TILE_DIM + 2;
  localparam int KER_DIM = 3;
  localparam int KER_SIZE = KER_DIM * KER_DIM;
  localparam int NUM_FILT = 2;
  // one window per output position
  localparam int NUM_WIN = TILE_DIM * TILE_DIM;
  localparam int WIN_IDX_LEN = $clog2(NUM_WIN);
  // 9 products of 8x8 bits fit in 20 bits
  localparam int PROD_LEN = 2 * DATA_LEN;
  localparam int ACC_LEN = 20;
  localparam int BIAS_LEN = 16;
  // one spare bit for the bias add
  localparam int SUM_LEN = ACC_LEN + 1;
  // requantization shift after the bias add
  localparam int OUT_SHIFT = 4;

  // sequencer states
  typedef enum logic [2:0] {
    CIDL = 3'd0,
    ZPAD = 3'd1,
    IM2C = 3'd2,
    DOTP = 3'd3,
    BIAS = 3'd4,
    FINI = 3'd5
  } state_e;

  typedef logic signed [DATA_LEN-1:0] sample_t;
  typedef logic signed [PROD_LEN-1:0] prod_t;
  typedef logic signed [ACC_LEN-1:0] acc_t;
  typedef logic signed [BIAS_LEN-1:0] bias_val_t;
  typedef logic signed [SUM_LEN-1:0] sum_t;

  // saturation bounds of the output range
  localparam sum_t SAT_MAX = sum_t'(2 ** (DATA_LEN - 1) - 1);
  localparam sum_t SAT_MIN = sum_t'(-(2 ** (DATA_LEN - 1)));

  // element 0 sits in the low bits, row-major
  typedef struct packed {sample_t [NUM_WIN-1:0] px;} tile_t;
  typedef struct packed {sample_t [PAD_DIM*PAD_DIM-1:0] px;} padded_t;
  typedef struct packed {sample_t [KER_SIZE-1:0] px;} window_t;
  // window index is out row * 4 + out col
  typedef struct packed {window_t [NUM_WIN-1:0] win;} win_map_t;
  typedef struct packed {sample_t [KER_SIZE-1:0] w;} kernel_t;
  typedef struct packed {kernel_t [NUM_FILT-1:0] ker;} weight_set_t;
  typedef struct packed {bias_val_t [NUM_FILT-1:0] b;} bias_t;
  typedef struct packed {acc_t [NUM_FILT-1:0] f;} acc_pair_t;
  typedef struct packed {acc_pair_t [NUM_WIN-1:0] pos;} acc_map_t;
  // index is position * 2 + filter
  typedef struct packed {sample_t [NUM_WIN*NUM_FILT-1:0] v;} out_map_t;

endpackage

// File: design/state_calc.sv
`timescale 1ns/10ps

module state_calc (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             load,
  input  logic             dot_done,
  output cnn_pkg::state_e  state,
  output logic             zpad_en,
  output logic             im2c_en,
  output logic             dot_en,
  output logic             bias_en
);

  cnn_pkg::state_e state_nxt;
  logic advance;

  // fixed stages always advance
  // dotp waits for its stage, idle and fini wait for a load
  assign advance = ((state == cnn_pkg::CIDL) & load) |
                   (state == cnn_pkg::ZPAD) |
                   (state == cnn_pkg::IM2C) |
                   ((state == cnn_pkg::DOTP) & dot_done) |
                   (state == cnn_pkg::BIAS) |
                   ((state == cnn_pkg::FINI) & load);

  always_comb begin
    state_nxt = state;
    if (advance) begin
      case (state)
        cnn_pkg::CIDL: state_nxt = cnn_pkg::ZPAD;
        cnn_pkg::ZPAD: state_nxt = cnn_pkg::IM2C;
        cnn_pkg::IM2C: state_nxt = cnn_pkg::DOTP;
        cnn_pkg::DOTP: state_nxt = cnn_pkg::BIAS;
        cnn_pkg::BIAS: state_nxt = cnn_pkg::FINI;
        // a new run straight from a held result
        cnn_pkg::FINI: state_nxt = cnn_pkg::ZPAD;
        default:       state_nxt = cnn_pkg::CIDL;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= cnn_pkg::CIDL;
    end else begin
      state <= state_nxt;
    end
  end

  // one-cycle strobes, dot_en is a level over all of dotp
  assign zpad_en = (state == cnn_pkg::ZPAD);
  assign im2c_en = (state == cnn_pkg::IM2C);
  assign dot_en  = (state == cnn_pkg::DOTP);
  assign bias_en = (state == cnn_pkg::BIAS);

  // the dot engine must not finish outside its own state
  a_done_in_dotp : assert property (@(posedge clk) disable iff (!arst_n)
    dot_done |-> state == cnn_pkg::DOTP);

  a_state_legal : assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(state) && state inside {cnn_pkg::CIDL, cnn_pkg::ZPAD, cnn_pkg::IM2C,
                                        cnn_pkg::DOTP, cnn_pkg::BIAS, cnn_pkg::FINI});

endmodule

// File: design/zero_padding.sv
`timescale 1ns/10ps

module zero_padding (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             zpad_en,
  input  cnn_pkg::tile_t   d,
  output cnn_pkg::padded_t q
);

  cnn_pkg::padded_t padded;

  always_comb begin
    // border ring stays zero
    padded = '0;
    // tile lands one row down and one column in
    for (int r = 0; r < cnn_pkg::TILE_DIM; r++) begin
      for (int c = 0; c < cnn_pkg::TILE_DIM; c++) begin
        padded.px[(r + 1) * cnn_pkg::PAD_DIM + c + 1] = d.px[r * cnn_pkg::TILE_DIM + c];
      end
    end
  end

  // d sampled in the zpad cycle only
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (zpad_en) begin
      q <= padded;
    end
  end

endmodule

// File: design/im2col.sv
`timescale 1ns/10ps

module im2col (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              im2c_en,
  input  cnn_pkg::padded_t  d,
  output cnn_pkg::win_map_t q
);

  cnn_pkg::win_map_t windows;

  always_comb begin
    windows = '0;
    // one window per output position, stride 1
    for (int orow = 0; orow < cnn_pkg::TILE_DIM; orow++) begin
      for (int ocol = 0; ocol < cnn_pkg::TILE_DIM; ocol++) begin
        // window pixels in row-major order
        for (int kr = 0; kr < cnn_pkg::KER_DIM; kr++) begin
          for (int kc = 0; kc < cnn_pkg::KER_DIM; kc++) begin
            windows.win[orow * cnn_pkg::TILE_DIM + ocol].px[kr * cnn_pkg::KER_DIM + kc] =
              d.px[(orow + kr) * cnn_pkg::PAD_DIM + ocol + kc];
          end
        end
      end
    end
  end

  // whole window map captured in one go
  // dot then picks windows by index
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (im2c_en) begin
      q <= windows;
    end
  end

endmodule

// File: design/dot.sv
`timescale 1ns/10ps

module dot (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 dot_en,
  input  cnn_pkg::win_map_t    d,
  input  cnn_pkg::weight_set_t weights,
  output logic                 dot_done,
  output cnn_pkg::acc_map_t    q
);

  logic [cnn_pkg::WIN_IDX_LEN-1:0] win_idx;
  cnn_pkg::window_t  win;
  cnn_pkg::acc_pair_t pair;

  // window under work this cycle
  assign win = d.win[win_idx];

  // two nine-term mac trees, one per filter
  always_comb begin : mac
    cnn_pkg::prod_t prod;
    cnn_pkg::acc_t  sum;
    pair = '0;
    for (int f = 0; f < cnn_pkg::NUM_FILT; f++) begin
      sum = '0;
      for (int k = 0; k < cnn_pkg::KER_SIZE; k++) begin
        prod = $signed(win.px[k]) * $signed(weights.ker[f].w[k]);
        // sign-extend product before summing
        sum = sum + cnn_pkg::acc_t'(prod);
      end
      pair.f[f] = sum;
    end
  end

  // last window of the tile
  assign dot_done = dot_en && (win_idx == cnn_pkg::WIN_IDX_LEN'(cnn_pkg::NUM_WIN - 1));

  // one acc pair per cycle, window 0 first
  // counter wraps to 0 as dotp ends
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      win_idx <= '0;
      q       <= '0;
    end else if (dot_en) begin
      q.pos[win_idx] <= pair;
      win_idx        <= win_idx + 1'b1;
    end
  end

  // counter frozen outside dotp
  a_idx_hold : assert property (@(posedge clk) disable iff (!arst_n)
    !dot_en |=> $stable(win_idx));

endmodule

// File: design/add_bias.sv
`timescale 1ns/10ps

module add_bias (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              bias_en,
  input  cnn_pkg::acc_map_t d,
  input  cnn_pkg::bias_t    bias,
  output cnn_pkg::out_map_t q
);

  cnn_pkg::out_map_t res;

  always_comb begin : requant
    cnn_pkg::sum_t sum;
    cnn_pkg::sum_t shifted;
    res = '0;
    for (int p = 0; p < cnn_pkg::NUM_WIN; p++) begin
      for (int f = 0; f < cnn_pkg::NUM_FILT; f++) begin
        // both operands sign-extended to the sum width
        sum = cnn_pkg::sum_t'(d.pos[p].f[f]) + cnn_pkg::sum_t'(bias.b[f]);
        // arithmetic shift rounds toward minus infinity
        shifted = sum >>> cnn_pkg::OUT_SHIFT;
        // clamp into signed 8 bits
        if (shifted > cnn_pkg::SAT_MAX) begin
          res.v[p * cnn_pkg::NUM_FILT + f] = cnn_pkg::sample_t'(cnn_pkg::SAT_MAX);
        end else if (shifted < cnn_pkg::SAT_MIN) begin
          res.v[p * cnn_pkg::NUM_FILT + f] = cnn_pkg::sample_t'(cnn_pkg::SAT_MIN);
        end else begin
          res.v[p * cnn_pkg::NUM_FILT + f] = cnn_pkg::sample_t'(shifted);
        end
      end
    end
  end

  // result map held until the next run's bias cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (bias_en) begin
      q <= res;
    end
  end

  // output map only moves right after a bias strobe
  a_q_hold : assert property (@(posedge clk) disable iff (!arst_n)
    !$stable(q) |-> $past(bias_en));

endmodule

// File: design/cnn_layer.sv
`timescale 1ns/10ps

module cnn_layer (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 load,
  input  cnn_pkg::tile_t       d,
  input  cnn_pkg::weight_set_t weights,
  input  cnn_pkg::bias_t       bias,
  output logic                 valid,
  output cnn_pkg::out_map_t    q
);

  // sequencer
  cnn_pkg::state_e cs_calc;
  logic zpad_en;
  logic im2c_en;
  logic dot_en;
  logic bias_en;
  logic dot_done;

  // stage to stage payloads
  cnn_pkg::padded_t  zpadout;
  cnn_pkg::win_map_t im2cout;
  cnn_pkg::acc_map_t dotout;

  // result held for the whole fini state
  assign valid = (cs_calc == cnn_pkg::FINI);

  state_calc state_calc_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .load     (load),
    .dot_done (dot_done),
    .state    (cs_calc),
    .zpad_en  (zpad_en),
    .im2c_en  (im2c_en),
    .dot_en   (dot_en),
    .bias_en  (bias_en)
  );

  zero_padding zero_padding_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .zpad_en (zpad_en),
    .d       (d),
    .q       (zpadout)
  );

  im2col im2col_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .im2c_en (im2c_en),
    .d       (zpadout),
    .q       (im2cout)
  );

  // multi-cycle stage, paces dotp through dot_done
  dot dot_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .dot_en   (dot_en),
    .d        (im2cout),
    .weights  (weights),
    .dot_done (dot_done),
    .q        (dotout)
  );

  add_bias add_bias_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .bias_en (bias_en),
    .d       (dotout),
    .bias    (bias),
    .q       (q)
  );

endmodule

// File: tests/tb_cnn_layer.sv
`timescale 1ns/10ps

module tb_cnn_layer;

  localparam int NUM_RUNS = 6;
  // tile, weights, bias, extra-load flag, expected map
  localparam int REC_LEN = 5;
  localparam int RESET_CYCLES = 5;
  // load edge to valid
  localparam int RUN_CYCLES = 20;
  // one run plus load cycle and up to 3 idle cycles
  localparam int RUN_SLOT = 24;
  localparam int CYCLE_LIMIT = NUM_RUNS * RUN_SLOT + RESET_CYCLES + 151;
  // mid-run load lands inside dotp
  localparam int EXTRA_LOAD_AT = 8;

  logic                 clk;
  logic                 arst_n;
  logic                 load;
  cnn_pkg::tile_t       d;
  cnn_pkg::weight_set_t weights;
  cnn_pkg::bias_t       bias;
  logic                 valid;
  cnn_pkg::out_map_t    q;

  logic [255:0] vec_mem [NUM_RUNS*REC_LEN];
  int cycle_cnt = 0;
  int seed = 32'he70b0448;

  cnn_layer u_cnn_layer (
    .clk     (clk),
    .arst_n  (arst_n),
    .load    (load),
    .d       (d),
    .weights (weights),
    .bias    (bias),
    .valid   (valid),
    .q       (q)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic stop_on_failure(input string why);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  // hard stop if a run never completes
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: simulation still running after %0d cycles", CYCLE_LIMIT);
      stop_on_failure("timeout");
    end
  end

  task automatic check_out_map(input cnn_pkg::out_map_t exp_map,
                               input cnn_pkg::out_map_t act_map);
    if (act_map !== exp_map) begin
      $display("MISMATCH q: expected %h, actual %h", exp_map, act_map);
      stop_on_failure("output map does not match");
    end
  endtask

  // level plus the cycle it was seen in
  task automatic check_valid(input logic exp_lvl, input logic act_lvl,
                             input int exp_cnt, input int act_cnt);
    if (act_lvl !== exp_lvl || act_cnt != exp_cnt) begin
      $display("MISMATCH valid: expected %h at cycle %h, actual %h at cycle %h",
               exp_lvl, exp_cnt, act_lvl, act_cnt);
      stop_on_failure("valid level or timing is wrong");
    end
  endtask

  initial begin
    int base;
    int cnt;
    int gap;
    logic extra;
    cnn_pkg::out_map_t exp_map;
    $readmemh("tests/cnn_vectors.hex", vec_mem);
    arst_n  = 1'b0;
    load    = 1'b0;
    d       = '0;
    weights = '0;
    bias    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    // idle out of reset, map cleared
    check_valid(1'b0, valid, 0, 0);
    check_out_map('0, q);
    for (int run = 0; run < NUM_RUNS; run++) begin
      base    = run * REC_LEN;
      extra   = vec_mem[base+3][0];
      exp_map = cnn_pkg::out_map_t'(vec_mem[base+4]);
      @(posedge clk);
      d       <= cnn_pkg::tile_t'(vec_mem[base][127:0]);
      weights <= cnn_pkg::weight_set_t'(vec_mem[base+1][143:0]);
      bias    <= cnn_pkg::bias_t'(vec_mem[base+2][31:0]);
      load    <= 1'b1;
      cnt = 0;
      while (cnt == 0 || valid !== 1'b1) begin
        @(posedge clk);
        cnt++;
        if (cnt == 1 || (extra && cnt == EXTRA_LOAD_AT + 1)) begin
          load <= 1'b0;
        end
        // stray load with a scrambled tile, must not disturb the run
        if (extra && cnt == EXTRA_LOAD_AT) begin
          load <= 1'b1;
          d    <= cnn_pkg::tile_t'(~vec_mem[base][127:0]);
        end
        @(negedge clk);
        // held result drops one cycle after the load
        if (cnt == 1) begin
          check_valid(1'b0, valid, 0, 0);
        end
      end
      check_valid(1'b1, valid, RUN_CYCLES, cnt);
      check_out_map(exp_map, q);
      // result held through the idle gap
      gap = $random(seed) & 3;
      repeat (gap) begin
        @(posedge clk);
        @(negedge clk);
        check_valid(1'b1, valid, 0, 0);
        check_out_map(exp_map, q);
      end
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: tests/cnn_vectors.hex
// per run: tile, weight set, bias, extra-load flag on one line
// then the expected out_map, element 0 in the lowest hex digits
// run 1, mixed-sign pixels and weights
10F10EF3F40BF60908F906FBFC03FE01 00F000000000002000000000F01000000000 00100000 0
E91017E1ED1D13E501F40217FFEB04130508FCF1070DFAF5F9FC0807FBFB0603
// run 2, corner pixels only
D800001E0000000000000000EC00000A 100000000000000010101010101010101010 FFE00000 0
FED8FED8FE1EFE1EFED8D6D8FE1EFE1EFEECFEEC080AFE0AFEECFEECFE0AFE0A
// run 3, saturation both ways, stray load mid-run
9C9C9C9C9C9C9C9C6464646464646464 8080808080808080807F7F7F7F7F7F7F7F7F 00000000 1
7F807F807F807F807F807F807F807F80807F807F807F807F807F807F807F807F
// run 4, negative bias and floor rounding of the shift
DB25807FFA1514F0100FEF0605FF0100 000000000300000000000000000100000000 0007FFFB 0
F9FD0702E8F71807FFFF04010400FDFE03000300FDFE0100010000FF00FF00FF
// run 5, negated box filter, stray load mid-run
10F10EF3F40BF60908F906FBFC03FE01 000000000000000000F0F0F0F0F0F0F0F0F0 00500000 1
050005FC0504050005FF05F5050A05FF0501050705FA0501050005FC05040500
// run 6, zero tile so only the bias shows
00000000000000000000000000000000 7F7F7F7F7F7F7F7F7F818181818181818181 FF9C0123 0
F912F912F912F912F912F912F912F912F912F912F912F912F912F912F912F912

// File: tb.f
design/cnn_pkg.sv
design/state_calc.sv
design/zero_padding.sv
design/im2col.sv
design/dot.sv
design/add_bias.sv
design/cnn_layer.sv
tests/tb_cnn_layer.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cnn_layer
FILELIST  ?= tb.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
